/* hw/disp_pkg.sv */
package disp_pkg;

    // panel geometry
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;
    localparam int ROW_IDX_W   = 3;

    // digit range
    localparam int DIGIT_W = 3;
    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 3'd7;

    // colour bands, upper bound of each band
    // 7..4 red, 3..2 yellow, 1..0 green
    localparam logic [DIGIT_W-1:0] YELLOW_MAX = 3'd3;
    localparam logic [DIGIT_W-1:0] GREEN_MAX  = 3'd1;

    // one colour's column drive, bit 7 is the leftmost column
    typedef logic [MATRIX_COLS-1:0] col_t;

    // active low, one zero bit selects the lit row
    typedef logic [MATRIX_ROWS-1:0] row_t;

endpackage

/* hw/timing_pkg.sv */
package timing_pkg;

    // 1 kHz row rate from a 50 MHz clock
    localparam int unsigned SCAN_DIV_DEF = 50000;

    // one count step per second at 50 MHz
    localparam int unsigned COUNT_DIV_DEF = 50000000;

endpackage

/* hw/glyph_if.sv */
`timescale 1ns/1ps

interface glyph_if;
    import disp_pkg::*;

    logic [DIGIT_W-1:0]   digit;
    logic [ROW_IDX_W-1:0] row_idx;
    col_t                 red;
    col_t                 green;

    // scanner asks for a row of the current digit
    modport scan (
        output digit,
        output row_idx,
        input  red,
        input  green
    );

    // table answers combinationally
    modport rom (
        input  digit,
        input  row_idx,
        output red,
        output green
    );

endinterface

/* hw/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
    parameter int unsigned SCAN_DIV  = timing_pkg::SCAN_DIV_DEF,
    parameter int unsigned COUNT_DIV = timing_pkg::COUNT_DIV_DEF
) (
    input  logic clk,
    input  logic rst,
    input  logic running,
    output logic scan_tick,
    output logic count_tick
);

    localparam int SCAN_W  = $clog2(SCAN_DIV);
    localparam int COUNT_W = $clog2(COUNT_DIV);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [COUNT_W-1:0] count_cnt;

    // free running row rate divider
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end
        else if (scan_cnt == SCAN_W'(SCAN_DIV - 1))
        begin
            scan_cnt  <= '0;
            scan_tick <= 1'b1;
        end
        else
        begin
            scan_cnt  <= scan_cnt + 1'b1;
            scan_tick <= 1'b0;
        end
    end

    // held at zero until a run starts, so the first step is a full period later
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count_cnt  <= '0;
            count_tick <= 1'b0;
        end
        else if (!running)
        begin
            count_cnt  <= '0;
            count_tick <= 1'b0;
        end
        else if (count_cnt == COUNT_W'(COUNT_DIV - 1))
        begin
            count_cnt  <= '0;
            count_tick <= 1'b1;
        end
        else
        begin
            count_cnt  <= count_cnt + 1'b1;
            count_tick <= 1'b0;
        end
    end

endmodule

/* hw/countdown.sv */
`timescale 1ns/1ps

module countdown (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        st,
    input  logic                        count_tick,
    output logic [disp_pkg::DIGIT_W-1:0] digit,
    output logic                        running,
    output logic                        done
);
    import disp_pkg::*;

    logic st_q;
    logic st_prev;
    logic st_rise;

    // registered start and its previous value for the edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            st_q    <= 1'b0;
            st_prev <= 1'b0;
        end
        else
        begin
            st_q    <= st;
            st_prev <= st_q;
        end
    end

    assign st_rise = st_q & ~st_prev;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit   <= DIGIT_MAX;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else if (!st_q)
        begin
            digit   <= DIGIT_MAX;
            running <= 1'b0;
            done    <= 1'b0;
        end
        else if (st_rise)
        begin
            digit   <= DIGIT_MAX;
            running <= 1'b1;
            done    <= 1'b0;
        end
        else if (running)
        begin
            if (count_tick && digit != '0)
                digit <= digit - 1'b1;
            // holds at zero once reached
            if (digit == '0)
                done <= 1'b1;
        end
    end

endmodule

/* hw/glyph_rom.sv */
`timescale 1ns/1ps

module glyph_rom (
    glyph_if.rom g
);
    import disp_pkg::*;

    // indexed by digit then row, row 0 left empty as a top margin
    localparam col_t GLYPH [0:(1 << DIGIT_W) - 1][0:MATRIX_ROWS-1] = '{
        '{
            8'b0000_0000,
            8'b0011_1100,
            8'b0100_0010,
            8'b0100_0010,
            8'b0100_0010,
            8'b0100_0010,
            8'b0100_0010,
            8'b0011_1100
        },
        '{
            8'b0000_0000,
            8'b0001_1000,
            8'b0011_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0001_1000,
            8'b0111_1110
        },
        '{
            8'b0000_0000,
            8'b0011_1100,
            8'b0110_0110,
            8'b0000_0110,
            8'b0000_1100,
            8'b0011_0000,
            8'b0110_0000,
            8'b0111_1110
        },
        '{
            8'b0000_0000,
            8'b0011_1100,
            8'b0110_0110,
            8'b0000_0110,
            8'b0001_1100,
            8'b0000_0110,
            8'b0110_0110,
            8'b0011_1100
        },
        '{
            8'b0000_0000,
            8'b0000_1100,
            8'b0001_1100,
            8'b0010_1100,
            8'b0100_1100,
            8'b0111_1110,
            8'b0000_1100,
            8'b0000_1100
        },
        '{
            8'b0000_0000,
            8'b0111_1110,
            8'b0110_0000,
            8'b0111_1100,
            8'b0000_0110,
            8'b0000_0110,
            8'b0110_0110,
            8'b0011_1100
        },
        '{
            8'b0000_0000,
            8'b0011_1100,
            8'b0110_0000,
            8'b0111_1100,
            8'b0110_0110,
            8'b0110_0110,
            8'b0110_0110,
            8'b0011_1100
        },
        '{
            8'b0000_0000,
            8'b0111_1110,
            8'b0000_0110,
            8'b0000_1100,
            8'b0001_1000,
            8'b0011_0000,
            8'b0011_0000,
            8'b0011_0000
        }
    };

    col_t bitmap;

    assign bitmap = GLYPH[g.digit][g.row_idx];

    // colour by urgency band
    always_comb
    begin
        if (g.digit <= GREEN_MAX)
        begin
            g.red   = '0;
            g.green = bitmap;
        end
        else if (g.digit <= YELLOW_MAX)
        begin
            // yellow is both dies lit
            g.red   = bitmap;
            g.green = bitmap;
        end
        else
        begin
            g.red   = bitmap;
            g.green = '0;
        end
    end

endmodule

/* hw/matrix_scan.sv */
`timescale 1ns/1ps

module matrix_scan (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         running,
    input  logic                         scan_tick,
    input  logic [disp_pkg::DIGIT_W-1:0] digit,
    glyph_if.scan                        g,
    output disp_pkg::row_t               row,
    output disp_pkg::col_t               colr,
    output disp_pkg::col_t               colg
);
    import disp_pkg::*;

    logic [ROW_IDX_W-1:0] row_idx;

    // row pointer, wraps 7 -> 0 by width
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (!running)
            row_idx <= '0;
        else if (scan_tick)
            row_idx <= row_idx + 1'b1;
    end

    assign g.row_idx = row_idx;
    assign g.digit   = digit;

    // row select and both colours sampled together so they never mismatch
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else if (!running)
        begin
            row  <= '1;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(row_t'(1) << row_idx);
            colr <= g.red;
            colg <= g.green;
        end
    end

endmodule

/* hw/dot_timer_top.sv */
`timescale 1ns/1ps

module dot_timer_top #(
    parameter int unsigned SCAN_DIV  = timing_pkg::SCAN_DIV_DEF,
    parameter int unsigned COUNT_DIV = timing_pkg::COUNT_DIV_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         st,
    output disp_pkg::row_t               row,
    output disp_pkg::col_t               colr,
    output disp_pkg::col_t               colg,
    output logic [disp_pkg::DIGIT_W-1:0] digit,
    output logic                         done
);

    logic scan_tick;
    logic count_tick;
    logic running;

    glyph_if glyph_bus ();

    tick_gen #(
        .SCAN_DIV  (SCAN_DIV),
        .COUNT_DIV (COUNT_DIV)
    ) tick_gen_i (
        .clk        (clk),
        .rst        (rst),
        .running    (running),
        .scan_tick  (scan_tick),
        .count_tick (count_tick)
    );

    countdown countdown_i (
        .clk        (clk),
        .rst        (rst),
        .st         (st),
        .count_tick (count_tick),
        .digit      (digit),
        .running    (running),
        .done       (done)
    );

    matrix_scan matrix_scan_i (
        .clk       (clk),
        .rst       (rst),
        .running   (running),
        .scan_tick (scan_tick),
        .digit     (digit),
        .g         (glyph_bus.scan),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

    glyph_rom glyph_rom_i (
        .g (glyph_bus.rom)
    );

endmodule

/* bench/dot_timer_chk.sv */
`timescale 1ns/1ps

module dot_timer_chk (
    input logic                           clk,
    input logic                           rst,
    input logic                           running,
    input logic                           scan_tick,
    input logic [disp_pkg::ROW_IDX_W-1:0] row_idx,
    input disp_pkg::row_t                 row,
    input disp_pkg::col_t                 colr,
    input disp_pkg::col_t                 colg
);

    // blank or exactly one row pulled low
    row_one_low: assert property (@(posedge clk) disable iff (rst)
        row == '1 || $onehot(~row))
        else $error("row drive selects more than one row");

    blank_cols_off: assert property (@(posedge clk) disable iff (rst)
        row == '1 |-> colr == '0 && colg == '0)
        else $error("columns driven while the panel is blank");

    // the pointer only moves on a scan tick, or falls back to 0 when stopped
    row_idx_on_tick: assert property (@(posedge clk) disable iff (rst)
        row_idx != $past(row_idx) |-> $past(scan_tick) || !$past(running))
        else $error("row index moved without a scan tick");

endmodule

bind matrix_scan dot_timer_chk row_chk_i (
    .clk       (clk),
    .rst       (rst),
    .running   (running),
    .scan_tick (scan_tick),
    .row_idx   (row_idx),
    .row       (row),
    .colr      (colr),
    .colg      (colg)
);

/* bench/dot_timer_tb.sv */
`timescale 1ns/1ps

module dot_timer_tb;

    localparam int SCAN_DIV  = 4;
    localparam int COUNT_DIV = 200;

    logic       clk;
    logic       rst;
    logic       st;
    logic [7:0] row;
    logic [7:0] colr;
    logic [7:0] colg;
    logic [2:0] digit;
    logic       done;

    logic [15:0] lfsr;
    int          checks;
    int          run;
    int          gap;

    // comparison process state
    int          cyc;
    int          last_change;
    bit          have_last;
    int          idle_cnt;
    int          prev_k;
    int          lit_k;
    int          dwell;
    logic [2:0]  prev_digit;
    logic [2:0]  step_exp;
    logic [15:0] exp_cols;

    dot_timer_top #(
        .SCAN_DIV  (SCAN_DIV),
        .COUNT_DIV (COUNT_DIV)
    ) dot_timer_i (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .row   (row),
        .colr  (colr),
        .colg  (colg),
        .digit (digit),
        .done  (done)
    );

    always #50 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // expected {red, green} for one row of a digit, row 0 in the top byte
    function automatic logic [15:0] expected_cols(input logic [2:0] d, input int r);
        logic [63:0] bits;
        logic [7:0]  line;
        case (d)
            3'd0: bits = 64'h003C_4242_4242_423C;
            3'd1: bits = 64'h0018_3818_1818_187E;
            3'd2: bits = 64'h003C_6606_0C30_607E;
            3'd3: bits = 64'h003C_6606_1C06_663C;
            3'd4: bits = 64'h000C_1C2C_4C7E_0C0C;
            3'd5: bits = 64'h007E_607C_0606_663C;
            3'd6: bits = 64'h003C_607C_6666_663C;
            default: bits = 64'h007E_060C_1830_3030;
        endcase
        line = bits[63 - 8 * r -: 8];
        if (d >= 3'd4)
            return {line, 8'h00};
        if (d >= 3'd2)
            return {line, line};
        return {8'h00, line};
    endfunction

    // -1 when blank, -2 when more than one row is low
    function automatic int zero_pos(input logic [7:0] r);
        int pos;
        int zeros;
        pos = -1;
        zeros = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (r[i] !== 1'b1)
            begin
                zeros++;
                pos = i;
            end
        end
        if (zeros > 1)
            return -2;
        return pos;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            report_failure("stopping at the first mismatch");
        end
    endtask

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            val = (val << 1) | lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic digit_reached(input logic [2:0] value, input int limit);
        int n;
        n = 0;
        while (digit !== value)
        begin
            if (n >= limit)
                report_failure($sformatf("digit never reached %0d", value));
            @(negedge clk);
            n++;
        end
    endtask

    task automatic done_within(input int limit);
        int n;
        n = 0;
        while (done !== 1'b1)
        begin
            if (n >= limit)
                report_failure("done did not rise after the count reached zero");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic settle_blank(input int limit);
        int n;
        n = 0;
        while (!(row === 8'hFF && digit === 3'd7 && done === 1'b0))
        begin
            if (n >= limit)
                report_failure("display did not return to idle after start dropped");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic count_to_zero();
        int hold;
        digit_reached(3'd0, 9 * COUNT_DIV);
        done_within(4);
        take_bits(5, hold);
        repeat (hold + 8)
        begin
            @(negedge clk);
            check_value("done", done, 1);
            check_value("digit", digit, 0);
        end
    endtask

    task automatic stop_midway();
        int pick;
        int extra;
        take_bits(3, pick);
        digit_reached(3'(pick % 6 + 1), 9 * COUNT_DIV);
        take_bits(6, extra);
        repeat (extra) @(negedge clk);
        check_value("done", done, 0);
    endtask

    // outputs are compared half a cycle after each rising edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            cyc = 0;
            have_last = 0;
            idle_cnt = 0;
            prev_k = -1;
            dwell = 0;
            prev_digit = 3'd7;
        end
        else
        begin
            cyc++;
            lit_k = zero_pos(row);
            if (lit_k == -2)
                report_failure("row drive has more than one row low");
            if (lit_k >= 0)
            begin
                // columns were registered with the digit of the previous cycle
                exp_cols = expected_cols(prev_digit, lit_k);
                check_value("colr", colr, exp_cols[15:8]);
                check_value("colg", colg, exp_cols[7:0]);
                if (prev_k < 0)
                    check_value("row index", lit_k, 0);
                else if (lit_k != prev_k)
                    check_value("row index", lit_k, (prev_k + 1) % 8);
            end
            // a row is held for one scan period at most
            if (lit_k >= 0 && lit_k == prev_k)
                dwell++;
            else
                dwell = 0;
            if (dwell >= SCAN_DIV)
                report_failure("row scan stopped advancing while running");
            if (st === 1'b0)
                idle_cnt++;
            else
                idle_cnt = 0;
            if (idle_cnt >= 4)
            begin
                check_value("row", row, 8'hFF);
                check_value("colr", colr, 0);
                check_value("colg", colg, 0);
                check_value("done", done, 0);
                check_value("digit", digit, 7);
            end
            if (digit !== prev_digit)
            begin
                if (digit === 3'd7)
                begin
                    if (idle_cnt == 0)
                        report_failure("digit went back to 7 while start was high");
                    have_last = 0;
                end
                else
                begin
                    step_exp = prev_digit - 3'd1;
                    check_value("digit", digit, step_exp);
                    if (have_last)
                        check_value("digit step interval", cyc - last_change, COUNT_DIV);
                    have_last = 1;
                    last_change = cyc;
                end
            end
            if (done === 1'b1)
                check_value("digit", digit, 0);
            prev_digit = digit;
            prev_k = lit_k;
        end
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        st = 1'b0;
        lfsr = 16'd49503;
        checks = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // even runs count to zero, odd runs are cut short
        for (run = 0; run < 4; run++)
        begin
            take_bits(4, gap);
            repeat (gap + 6) @(posedge clk);
            st <= 1'b1;
            if (run % 2 == 0)
                count_to_zero();
            else
                stop_midway();
            @(posedge clk);
            st <= 1'b0;
            settle_blank(20);
        end
        repeat (8) @(posedge clk);
        if (checks == 0)
            report_failure("no output was ever compared");
        else
        begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* sources.f */
hw/disp_pkg.sv
hw/timing_pkg.sv
hw/glyph_if.sv
hw/tick_gen.sv
hw/countdown.sv
hw/glyph_rom.sv
hw/matrix_scan.sv
hw/dot_timer_top.sv
bench/dot_timer_chk.sv
bench/dot_timer_tb.sv
